// File: hdl/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

////////////////////
// data path

`define DC_WORD_W   32

////////////////////
// address split
// addr = tag | index | word offset | byte

`define DC_TAG_W    22
`define DC_INDEX_W  4
`define DC_OFFSET_W 4   // 16 words per line

////////////////////
// associativity

`define DC_WAYS     4

`endif

// File: hdl/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

  typedef logic [`DC_WORD_W-1:0]   word_t;
  typedef logic [`DC_WORD_W/8-1:0] strb_t;   // one enable per byte

  // address fields
  typedef logic [`DC_TAG_W-1:0]    tag_t;
  typedef logic [`DC_INDEX_W-1:0]  index_t;
  typedef logic [`DC_OFFSET_W-1:0] offset_t;

  typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

  // 0 is the most recent way of a set
  typedef logic [$clog2(`DC_WAYS)-1:0] age_t;

  // word 0 sits in the low bits
  typedef word_t [2**`DC_OFFSET_W-1:0] line_t;

  // per way bookkeeping
  typedef struct packed
  {
    logic valid;
    logic dirty;
    age_t age;
  } meta_t;

endpackage

// File: hdl/set_ram.sv
`timescale 1ns/1ps

module set_ram
  #(
  parameter type entry_t = dcache_pkg::word_t
  )
  (
  input  logic               clk,
  input  logic               rst,
  input  dcache_pkg::index_t raddr,
  input  dcache_pkg::index_t waddr,
  input  logic               we,
  input  entry_t             wdata,
  output entry_t             rdata
  );
  import dcache_pkg::*;

  localparam int depth = 2**$bits(index_t);

  entry_t mem [depth];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < depth; i++)
        mem[i] <= '0;
    end
    else if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // read port is combinational, new data shows after the edge
  assign rdata = mem[raddr];

endmodule

// File: hdl/way_select.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module way_select
  (
  input  dcache_pkg::tag_t  [`DC_WAYS-1:0] tags,
  input  dcache_pkg::tag_t                 tag,
  input  dcache_pkg::meta_t [`DC_WAYS-1:0] meta,
  input  dcache_pkg::way_t                 access_way,
  output logic                             hit,
  output dcache_pkg::way_t                 hit_way,
  output dcache_pkg::way_t                 victim,
  output dcache_pkg::meta_t [`DC_WAYS-1:0] meta_next
  );
  import dcache_pkg::*;

  logic [`DC_WAYS-1:0] hit_vec;
  logic                free_found;
  age_t                ref_age;

  ////////////////////
  // lookup

  always_comb
  begin
    for (int w = 0; w < `DC_WAYS; w++)
      hit_vec[w] = meta[w].valid && (tags[w] == tag);
  end

  always_comb
  begin
    hit_way = '0;
    for (int w = `DC_WAYS-1; w >= 0; w--)
      if (hit_vec[w])
        hit_way = way_t'(w);
  end

  assign hit = |hit_vec;

  ////////////////////
  // replacement

  always_comb
  begin
    victim     = '0;
    free_found = 1'b0;
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (!meta[w].valid && !free_found)
      begin
        victim     = way_t'(w);
        free_found = 1'b1;
      end
    end
    if (!free_found)
    begin
      for (int w = 1; w < `DC_WAYS; w++)
        if (meta[w].age > meta[victim].age)   // strict, ties keep the low way
          victim = way_t'(w);
    end
  end

  // a fresh fill counts as oldest so all valid ways move up
  assign ref_age = meta[access_way].valid ? meta[access_way].age : age_t'(`DC_WAYS-1);

  always_comb
  begin
    meta_next = meta;
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (way_t'(w) == access_way)
        meta_next[w].age = '0;
      else if (meta[w].valid && meta[w].age < ref_age)
        meta_next[w].age = meta[w].age + 1'b1;
    end
  end

  always_comb
  begin
    a_one_hit : assert final ($onehot0(hit_vec))
      else $error("way_select: tag %h present in more than one way", tag);
  end

endmodule

// File: hdl/mem_port.sv
`timescale 1ns/1ps

module mem_port
  (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              evict,
  input  dcache_pkg::word_t evict_base,
  input  dcache_pkg::line_t evict_line,
  input  dcache_pkg::word_t fill_base,
  input  logic              rdata_ok,
  input  logic              wdata_ok,
  input  dcache_pkg::word_t sdata,
  output logic              sen,
  output logic              wen,
  output dcache_pkg::word_t raddr,
  output dcache_pkg::word_t waddr,
  output dcache_pkg::word_t wdata,
  output dcache_pkg::line_t fill_line,
  output logic              done
  );
  import dcache_pkg::*;

  typedef enum logic [1:0] {ph_idle, ph_wback, ph_fill} phase_t;

  phase_t  phase;
  offset_t cnt;    // word within the burst
  logic    last;

  assign last = &cnt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      phase <= ph_idle;
      cnt   <= '0;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (phase)
        ph_idle:
          if (start)
          begin
            phase <= evict ? ph_wback : ph_fill;
            cnt   <= '0;
          end
        ph_wback:
          if (wdata_ok)
          begin
            cnt <= cnt + 1'b1;
            if (last)
              phase <= ph_fill;   // cnt wraps back to word 0
          end
        ph_fill:
          if (rdata_ok)
          begin
            cnt <= cnt + 1'b1;
            if (last)
            begin
              phase <= ph_idle;
              done  <= 1'b1;
            end
          end
        default:
          phase <= ph_idle;
      endcase
    end
  end

  // refill words arrive in order
  always_ff @(posedge clk)
  begin
    if (phase == ph_fill && rdata_ok)
      fill_line[cnt] <= sdata;
  end

  assign sen   = (phase == ph_fill);
  assign wen   = (phase == ph_wback);
  assign raddr = fill_base;
  assign waddr = evict_base;
  assign wdata = evict_line[cnt];   // held until acknowledged

  ////////////////////
  // checks

  a_no_restart : assert property (@(posedge clk) disable iff (rst)
    start |-> phase == ph_idle)
    else $error("mem_port: start while a burst is running");

endmodule

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl
  (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             req,
  input  logic                             wreq,
  input  dcache_pkg::word_t                addr,
  input  dcache_pkg::word_t                din,
  input  dcache_pkg::strb_t                wbyte,
  input  logic                             hit,
  input  dcache_pkg::way_t                 hit_way,
  input  dcache_pkg::way_t                 victim,
  input  dcache_pkg::meta_t [`DC_WAYS-1:0] meta,
  input  dcache_pkg::meta_t [`DC_WAYS-1:0] meta_next,
  input  dcache_pkg::line_t                line,
  input  dcache_pkg::line_t                fill_line,
  input  dcache_pkg::tag_t                 victim_tag,
  input  logic                             done,
  output dcache_pkg::word_t                ins,
  output logic                             ok,
  output logic                             miss,
  output dcache_pkg::way_t                 access_way,
  output dcache_pkg::index_t               index,
  output logic [`DC_WAYS-1:0]              tag_we,
  output logic [`DC_WAYS-1:0]              line_we,
  output dcache_pkg::line_t                line_wdata,
  output logic                             meta_we,
  output dcache_pkg::meta_t [`DC_WAYS-1:0] meta_wdata,
  output logic                             start,
  output logic                             evict,
  output dcache_pkg::word_t                evict_base,
  output dcache_pkg::word_t                fill_base
  );
  import dcache_pkg::*;

  localparam int off_lo = $clog2(`DC_WORD_W/8);
  localparam int idx_lo = off_lo + `DC_OFFSET_W;

  typedef enum logic [1:0] {s_idle, s_memory, s_update} state_t;

  state_t  state;
  logic    idle;
  logic    lookup;    // idle cycle with a request

  // request kept across a miss
  word_t   req_addr;
  logic    req_wreq;
  word_t   req_din;
  strb_t   req_wbyte;
  way_t    req_way;

  word_t   cur_addr;
  logic    cur_wreq;
  word_t   cur_din;
  strb_t   cur_wbyte;
  offset_t offset;
  line_t   src_line;

  function automatic line_t merge_word(line_t l, offset_t off, word_t d, strb_t be);
    line_t r;
    r = l;
    for (int b = 0; b < $bits(strb_t); b++)
      if (be[b])
        r[off][8*b +: 8] = d[8*b +: 8];
    return r;
  endfunction

  assign idle   = (state == s_idle);
  assign lookup = idle && req;

  assign cur_addr  = idle ? addr  : req_addr;
  assign cur_wreq  = idle ? wreq  : req_wreq;
  assign cur_din   = idle ? din   : req_din;
  assign cur_wbyte = idle ? wbyte : req_wbyte;

  assign offset     = cur_addr[idx_lo-1:off_lo];
  assign index      = cur_addr[idx_lo +: `DC_INDEX_W];
  assign access_way = idle ? (hit ? hit_way : victim) : req_way;

  // hit writes merge into the cached line, misses into the refill
  assign src_line   = idle ? line : fill_line;
  assign line_wdata = cur_wreq ? merge_word(src_line, offset, cur_din, cur_wbyte) : src_line;

  assign evict_base = {victim_tag, index, {idx_lo{1'b0}}};
  assign fill_base  = {req_addr[`DC_WORD_W-1:idx_lo], {idx_lo{1'b0}}};

  ////////////////////
  // array writes

  always_comb
  begin
    tag_we     = '0;
    line_we    = '0;
    meta_we    = 1'b0;
    meta_wdata = meta_next;
    if (lookup && hit)
    begin
      line_we[hit_way] = cur_wreq;
      meta_we          = 1'b1;
      if (cur_wreq)
        meta_wdata[hit_way].dirty = 1'b1;
    end
    else if (state == s_update)
    begin
      tag_we[req_way]           = 1'b1;
      line_we[req_way]          = 1'b1;
      meta_we                   = 1'b1;
      meta_wdata[req_way].valid = 1'b1;
      meta_wdata[req_way].dirty = req_wreq;
    end
  end

  ////////////////////
  // fsm

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= s_idle;
      ok    <= 1'b0;
      miss  <= 1'b0;
      start <= 1'b0;
      evict <= 1'b0;
    end
    else
    begin
      ok    <= 1'b0;
      start <= 1'b0;
      if (ok)
        miss <= 1'b0;
      case (state)
        s_idle:
          if (req)
          begin
            if (hit)
              ok <= 1'b1;
            else
            begin
              state <= s_memory;
              miss  <= 1'b1;
              start <= 1'b1;
              evict <= meta[victim].valid && meta[victim].dirty;
            end
          end
        s_memory:
          if (done)
            state <= s_update;
        s_update:
        begin
          state <= s_idle;
          ok    <= 1'b1;
        end
        default:
          state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (lookup)
    begin
      req_addr  <= addr;
      req_wreq  <= wreq;
      req_din   <= din;
      req_wbyte <= wbyte;
      req_way   <= victim;
    end
    if (lookup || state == s_update)
      ins <= line_wdata[offset];   // word as it stands after this request
  end

  a_ok_pulse : assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else $error("dcache_ctrl: ok held for two cycles");

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top
  (
  input  logic              clk,
  input  logic              rst,
  // cpu side
  input  logic              req,
  input  logic              wreq,
  input  dcache_pkg::word_t addr,
  input  dcache_pkg::word_t din,
  input  dcache_pkg::strb_t wbyte,
  output dcache_pkg::word_t ins,
  output logic              ok,
  output logic              miss,
  // memory side
  output logic              sen,
  output dcache_pkg::word_t raddr,
  input  logic              rdata_ok,
  input  dcache_pkg::word_t sdata,
  output logic              wen,
  output dcache_pkg::word_t waddr,
  output dcache_pkg::word_t wdata,
  input  logic              wdata_ok
  );
  import dcache_pkg::*;

  typedef meta_t [`DC_WAYS-1:0] meta_set_t;

  tag_t                 cpu_tag;
  tag_t                 fill_tag;
  index_t               index;
  way_t                 access_way;
  tag_t  [`DC_WAYS-1:0] tag_rd;
  line_t [`DC_WAYS-1:0] line_rd;
  line_t                sel_line;
  tag_t                 sel_tag;
  meta_set_t            meta_rd;
  meta_set_t            meta_next;
  meta_set_t            meta_wdata;
  logic                 meta_we;
  logic  [`DC_WAYS-1:0] tag_we;
  logic  [`DC_WAYS-1:0] line_we;
  line_t                line_wdata;
  logic                 hit;
  way_t                 hit_way;
  way_t                 victim;
  logic                 start;
  logic                 evict;
  word_t                evict_base;
  word_t                fill_base;
  line_t                fill_line;
  logic                 done;

  // tag of the request and of the line being filled
  assign cpu_tag  = addr[`DC_WORD_W-1 -: `DC_TAG_W];
  assign fill_tag = fill_base[`DC_WORD_W-1 -: `DC_TAG_W];

  assign sel_line = line_rd[access_way];
  assign sel_tag  = tag_rd[access_way];

  ////////////////////
  // storage

  for (genvar w = 0; w < `DC_WAYS; w++)
  begin : g_way
    set_ram #(.entry_t(tag_t)) tag_ram (
      .clk(clk), .rst(rst), .raddr(index), .waddr(index),
      .we(tag_we[w]), .wdata(fill_tag), .rdata(tag_rd[w])
    );
    set_ram #(.entry_t(line_t)) line_ram (
      .clk(clk), .rst(rst), .raddr(index), .waddr(index),
      .we(line_we[w]), .wdata(line_wdata), .rdata(line_rd[w])
    );
  end

  set_ram #(.entry_t(meta_set_t)) meta_ram (
    .clk(clk), .rst(rst), .raddr(index), .waddr(index),
    .we(meta_we), .wdata(meta_wdata), .rdata(meta_rd)
  );

  way_select ws0 (
    .tags(tag_rd), .tag(cpu_tag), .meta(meta_rd), .access_way(access_way),
    .hit(hit), .hit_way(hit_way), .victim(victim), .meta_next(meta_next)
  );

  mem_port mp0 (
    .clk(clk), .rst(rst), .start(start), .evict(evict),
    .evict_base(evict_base), .evict_line(sel_line), .fill_base(fill_base),
    .rdata_ok(rdata_ok), .wdata_ok(wdata_ok), .sdata(sdata),
    .sen(sen), .wen(wen), .raddr(raddr), .waddr(waddr), .wdata(wdata),
    .fill_line(fill_line), .done(done)
  );

  dcache_ctrl ctrl0 (
    .clk(clk), .rst(rst), .req(req), .wreq(wreq), .addr(addr), .din(din),
    .wbyte(wbyte), .hit(hit), .hit_way(hit_way), .victim(victim),
    .meta(meta_rd), .meta_next(meta_next), .line(sel_line),
    .fill_line(fill_line), .victim_tag(sel_tag), .done(done),
    .ins(ins), .ok(ok), .miss(miss), .access_way(access_way), .index(index),
    .tag_we(tag_we), .line_we(line_we), .line_wdata(line_wdata),
    .meta_we(meta_we), .meta_wdata(meta_wdata), .start(start), .evict(evict),
    .evict_base(evict_base), .fill_base(fill_base)
  );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
  #(
  parameter real period     = 10.0,
  parameter int  rst_cycles = 4
  )
  (
  output logic clk,
  output logic rst
  );

  initial
  begin
    clk = 1'b0;
    forever #(period/2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    #1 rst = 1'b0;   // released off the edge
  end

endmodule

// File: testbench/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache;
  import dcache_pkg::*;

  logic  clk;
  logic  rst;
  logic  req;
  logic  wreq;
  word_t addr;
  word_t din;
  strb_t wbyte;
  word_t ins;
  logic  ok;
  logic  miss;
  logic  sen;
  word_t raddr;
  logic  rdata_ok;
  word_t sdata;
  logic  wen;
  word_t waddr;
  word_t wdata;
  logic  wdata_ok;

  int    seed;
  string test_name;

  word_t mem_arr [word_t];
  word_t shadow [word_t];               // every cpu write lands here
  word_t lru_q [2**`DC_INDEX_W][$];     // line bases per set, most recent first
  bit    dirty_line [word_t];
  bit    exp_rd_q [$];
  word_t exp_word_q [$];
  string exp_name_q [$];
  int    rd_cnt;
  int    wr_cnt;
  int    rd_bursts;
  int    wb_bursts;
  word_t last_raddr;
  word_t last_waddr;

  tb_clock clk0 (.clk(clk), .rst(rst));

  dcache_top dut0 (
    .clk(clk), .rst(rst),
    .req(req), .wreq(wreq), .addr(addr), .din(din), .wbyte(wbyte),
    .ins(ins), .ok(ok), .miss(miss),
    .sen(sen), .raddr(raddr), .rdata_ok(rdata_ok), .sdata(sdata),
    .wen(wen), .waddr(waddr), .wdata(wdata), .wdata_ok(wdata_ok)
  );

  ////////////////////
  // reference

  // power-up memory contents
  function automatic word_t fill_word(word_t a);
    return a ^ {a[7:0], a[31:8]} ^ 32'h3c96_a55a;
  endfunction

  function automatic word_t mem_read(word_t a);
    return mem_arr.exists(a) ? mem_arr[a] : fill_word(a);
  endfunction

  function automatic word_t ref_read(word_t a);
    return shadow.exists(a) ? shadow[a] : fill_word(a);
  endfunction

  function automatic void shadow_write(word_t a, word_t d, strb_t be);
    word_t w;
    w = ref_read(a);
    for (int b = 0; b < 4; b++)
      if (be[b])
        w[8*b +: 8] = d[8*b +: 8];
    shadow[a] = w;
  endfunction

  // true LRU per set, victim is the oldest entry
  task automatic lru_access(input word_t a, input bit wr, output bit hit_e,
                            output bit ev_e, output word_t ev_b);
    word_t base;
    int    s;
    int    pos;
    base = a & ~32'h3f;
    s    = int'(a[9:6]);
    pos  = -1;
    ev_e = 1'b0;
    ev_b = '0;
    for (int i = 0; i < lru_q[s].size(); i++)
      if (lru_q[s][i] == base)
        pos = i;
    hit_e = (pos >= 0);
    if (hit_e)
      lru_q[s].delete(pos);
    else if (lru_q[s].size() == `DC_WAYS)
    begin
      ev_b = lru_q[s].pop_back();
      ev_e = dirty_line[ev_b];
    end
    lru_q[s].push_front(base);
    if (wr)
      dirty_line[base] = 1'b1;
    else if (!hit_e)
      dirty_line[base] = 1'b0;
  endtask

  ////////////////////
  // checks

  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s failed: %s", test_name, msg);
    stop_run();
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp)
    begin
      $display("** Error: %s: word expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input word_t exp, input word_t act);
    if (act !== exp)
    begin
      $display("** Error: %s: address expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////
  // cpu side

  // called just after a rising edge, returns at the edge that sees ok
  task automatic access(input bit wr, input word_t a, input word_t d, input strb_t be);
    bit    hit_e;
    bit    ev_e;
    word_t ev_b;
    int    rd0;
    int    wb0;
    int    n;
    bit    got;
    bit    miss_seen;
    lru_access(a, wr, hit_e, ev_e, ev_b);
    rd0 = rd_bursts;
    wb0 = wb_bursts;
    exp_rd_q.push_back(!wr);
    exp_word_q.push_back(ref_read(a));
    exp_name_q.push_back(test_name);
    if (wr)
      shadow_write(a, d, be);
    #1;
    req   = 1'b1;
    wreq  = wr;
    addr  = a;
    din   = d;
    wbyte = be;
    @(posedge clk);
    #1;
    req  = 1'b0;
    wreq = 1'b0;
    n    = 0;
    got  = 1'b0;
    while (!got)
    begin
      @(posedge clk);
      n++;
      if (ok)
      begin
        got       = 1'b1;
        miss_seen = miss;
      end
      else if (n > 1000)
        report_failure("timeout waiting for ok");
    end
    if (hit_e)
    begin
      if (n != 1 || miss_seen)
        report_failure($sformatf("hit at %h answered after %0d cycles", a, n));
      if (rd_bursts != rd0 || wb_bursts != wb0)
        report_failure("memory burst during a hit");
    end
    else
    begin
      if (!miss_seen)
        report_failure("miss low in the ok cycle of a miss");
      if (rd_bursts != rd0 + 1)
        report_failure("miss without exactly one refill burst");
      check_addr(test_name, a & ~32'h3f, last_raddr);
      if (wb_bursts != wb0 + (ev_e ? 1 : 0))
        report_failure("write-back count differs from the LRU model");
      if (ev_e)
        check_addr(test_name, ev_b, last_waddr);
    end
  endtask

  // one expected entry per request
  always @(posedge clk)
  begin
    bit    is_rd;
    word_t w;
    string name;
    if (!rst && ok)
    begin
      if (exp_rd_q.size() == 0)
        report_failure("ok without an outstanding request");
      else
      begin
        is_rd = exp_rd_q.pop_front();
        w     = exp_word_q.pop_front();
        name  = exp_name_q.pop_front();
        if (is_rd)
          check_word(name, w, ins);
      end
    end
  end

  ////////////////////
  // memory model

  always @(posedge clk)
  begin
    int r;
    if (!rst)
    begin
      if (sen && wen)
        report_failure("sen and wen high together");
      if ((sen && rd_cnt == 16) || (wen && wr_cnt == 16))
        report_failure("burst runs past sixteen words");
      if (sen && rdata_ok)
      begin
        if (rd_cnt == 0)
        begin
          rd_bursts++;
          last_raddr = raddr;
        end
        check_addr(test_name, last_raddr, raddr);
        rd_cnt++;
      end
      else if (!sen)
        rd_cnt = 0;
      if (wen && wdata_ok)
      begin
        if (wr_cnt == 0)
        begin
          wb_bursts++;
          last_waddr = waddr;
        end
        check_addr(test_name, last_waddr, waddr);
        // victim words carry every cpu write
        check_word(test_name, ref_read(waddr + word_t'(wr_cnt * 4)), wdata);
        mem_arr[waddr + word_t'(wr_cnt * 4)] = wdata;
        wr_cnt++;
      end
      else if (!wen)
        wr_cnt = 0;
    end
    #1;
    r        = $random(seed);
    rdata_ok = sen && (r[1:0] != 2'b00);   // about one stall in four
    wdata_ok = wen && (r[3:2] != 2'b00);
    sdata    = mem_read(raddr + word_t'(rd_cnt * 4));
  end

  ////////////////////
  // tests

  initial
  begin
    int    n;
    int    r;
    int    wb0;
    word_t a;
    word_t d;
    word_t first_base;
    seed      = 32'hd053e9fc;
    rd_cnt    = 0;
    wr_cnt    = 0;
    rd_bursts = 0;
    wb_bursts = 0;
    req       = 1'b0;
    wreq      = 1'b0;
    addr      = '0;
    din       = '0;
    wbyte     = '0;
    rdata_ok  = 1'b0;
    wdata_ok  = 1'b0;
    sdata     = '0;

    test_name = "idle after reset";
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      if (n > 20)
        report_failure("reset never released");
    end
    while (rst);
    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk);
      if (ok || miss || sen || wen)
        report_failure("output active with no request");
    end

    test_name = "read miss then hit";
    access(1'b0, 32'h0001_2340, '0, '0);
    access(1'b0, 32'h0001_2344, '0, '0);

    test_name = "byte merge";
    access(1'b1, 32'h0001_2348, 32'h1122_3344, 4'b0001);
    access(1'b1, 32'h0001_2348, 32'haabb_ccdd, 4'b0110);
    access(1'b1, 32'h0001_2348, 32'h5566_7788, 4'b1000);
    access(1'b0, 32'h0001_2348, '0, '0);
    access(1'b1, 32'h0004_5348, 32'hdead_beef, 4'b0101);   // write miss
    access(1'b0, 32'h0004_5348, '0, '0);

    test_name  = "lru victim";
    wb0        = wb_bursts;
    first_base = {tag_t'(22'h2a0), index_t'(7), offset_t'(0), 2'b00};
    for (int t = 0; t < 5; t++)
    begin
      a = {tag_t'(22'h2a0 + t), index_t'(7), offset_t'(t), 2'b00};
      access(1'b1, a, 32'h0101_0101 * t, 4'hf);
    end
    if (wb_bursts != wb0 + 1)
      report_failure("fifth tag did not write back one line");
    check_addr(test_name, first_base, last_waddr);
    access(1'b0, first_base, '0, '0);   // second tag is now the oldest

    test_name = "random mix";
    for (int i = 0; i < 400; i++)
    begin
      r = $random(seed);
      d = $random(seed);
      a = {tag_t'(22'h3c0 + (r & 7) % 6), index_t'(2 + ((r >> 4) & 3)),
           offset_t'(r >> 8), 2'b00};
      access(r[12], a, d, strb_t'(r >> 13));
    end

    test_name = "drain";
    for (int i = 0; i < 10; i++)
      @(posedge clk);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/set_ram.sv
hdl/way_select.sv
hdl/mem_port.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/tb_clock.sv
testbench/tb_dcache.sv

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_dcache

out=$(./obj_dir/Vtb_dcache 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS"
